/* files.f */
+incdir+hdl
hdl/phold_pkg.sv
hdl/rr_arbiter.sv
hdl/event_queue.sv
hdl/prng_lfsr.sv
hdl/phold_core.sv
hdl/phold.sv
verif/phold_checker.sv
verif/phold_tb.sv

/* hdl/event_queue.sv */
`timescale 1ns/1ps
`include "phold_cfg.svh"

module event_queue (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                clear,
	input  logic                                enq,
	input  logic                                deq,
	input  phold_pkg::time_t                    in_time,
	input  phold_pkg::lp_t                      in_lp,
	output phold_pkg::time_t                    head_time,
	output phold_pkg::lp_t                      head_lp,
	output logic                                empty,
	output logic                                full,
	output logic [$clog2(`PHOLD_Q_DEPTH+1)-1:0] count
);

	localparam int D       = `PHOLD_Q_DEPTH;
	localparam int CNT_WID = $clog2(D + 1);
	localparam int IDX_WID = $clog2(D);

	phold_pkg::time_t   q_time [D];
	phold_pkg::lp_t     q_lp   [D];
	logic [CNT_WID-1:0] pos;     // Insert slot
	logic               do_enq;
	logic               do_deq;

	assign empty     = (count == '0);
	assign full      = (count == CNT_WID'(D));
	assign head_time = q_time[0];
	assign head_lp   = q_lp[0];
	assign do_enq    = enq && !full;
	assign do_deq    = deq && !empty && !enq;

	// Entries at or below in_time stay put, so ties keep arrival order
	always_comb begin
		pos = '0;
		for (int i = 0; i < D; i++) begin
			if (CNT_WID'(i) < count && q_time[i] <= in_time) begin
				pos = pos + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_enq) begin
			for (int i = D - 1; i > 0; i--) begin
				if (CNT_WID'(i) > pos) begin
					q_time[i] <= q_time[i-1];
					q_lp[i]   <= q_lp[i-1];
				end
			end
			q_time[pos[IDX_WID-1:0]] <= in_time;
			q_lp[pos[IDX_WID-1:0]]   <= in_lp;
		end else if (do_deq) begin
			for (int i = 0; i < D - 1; i++) begin
				q_time[i] <= q_time[i+1]; // Shift down over the head
				q_lp[i]   <= q_lp[i+1];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (do_enq) begin
			count <= count + 1'b1;
		end else if (do_deq) begin
			count <= count - 1'b1;
		end
	end

endmodule

/* hdl/phold.sv */
`timescale 1ns/1ps
`include "phold_cfg.svh"

module phold (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              start,
	input  logic [15:0]                       seed,
	input  phold_pkg::time_t                  end_time,
	output phold_pkg::time_t                  gvt,
	output logic                              done,
	output logic                              evt_vld,
	output phold_pkg::time_t                  evt_time,
	output phold_pkg::lp_t                    evt_lp,
	output logic [$clog2(`PHOLD_NUM_CORE)-1:0] evt_core
);

	localparam int N_CORE  = `PHOLD_NUM_CORE;
	localparam int IDX_WID = $clog2(N_CORE);
	localparam int CNT_WID = $clog2(`PHOLD_Q_DEPTH + 1);

	phold_pkg::ctrl_state_e state;
	phold_pkg::time_t       end_time_q;
	phold_pkg::time_t       gvt_next;

	logic [N_CORE-1:0]  rcv_req, rcv_vgnt, send_req, send_vgnt;
	logic [IDX_WID-1:0] rcv_egnt, send_egnt;
	logic               rcv_eval, send_eval;

	phold_pkg::time_t core_new_time  [N_CORE];
	phold_pkg::lp_t   core_new_lp    [N_CORE];
	phold_pkg::time_t core_busy_time [N_CORE];
	logic [N_CORE-1:0] core_held;

	logic               q_clear, q_enq, q_deq, q_empty, q_full;
	phold_pkg::time_t   q_in_time, q_head_time;
	phold_pkg::lp_t     q_in_lp, q_head_lp;
	logic [CNT_WID-1:0] q_count;
	logic [7:0]         rnd;

	assign q_clear = (state == phold_pkg::ST_IDLE) && start;

	// Finished cores go first, dispatch only when nothing is pending
	assign q_enq = (state == phold_pkg::ST_INIT)
		|| (state == phold_pkg::ST_RUNNING && rcv_eval && !q_full);
	assign q_deq = (state == phold_pkg::ST_RUNNING) && !rcv_eval && send_eval && !q_empty;

	// Init seeds LP n at time zero, with n taken from the queue fill level
	assign q_in_time = (state == phold_pkg::ST_INIT) ? '0 : core_new_time[rcv_egnt];
	assign q_in_lp   = (state == phold_pkg::ST_INIT) ? phold_pkg::lp_t'(q_count)
		: core_new_lp[rcv_egnt];

	assign evt_vld  = q_deq;
	assign evt_time = q_head_time;
	assign evt_lp   = q_head_lp;
	assign evt_core = send_egnt;

	// Lowest timestamp over queue head and held core events
	always_comb begin
		gvt_next = q_empty ? '1 : q_head_time;
		for (int i = 0; i < N_CORE; i++) begin
			if (core_held[i] && core_busy_time[i] < gvt_next) begin
				gvt_next = core_busy_time[i];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= phold_pkg::ST_IDLE;
			gvt   <= '0;
			done  <= 1'b0;
		end else begin
			done <= (state == phold_pkg::ST_RUNNING) && (gvt > end_time_q);
			case (state)
				phold_pkg::ST_IDLE: if (start) begin
					state <= phold_pkg::ST_INIT;
					gvt   <= '0;
				end
				phold_pkg::ST_INIT: if (q_count == CNT_WID'(`PHOLD_NUM_LP - 1)) begin
					state <= phold_pkg::ST_RUNNING; // Last seed goes in this cycle
				end
				phold_pkg::ST_RUNNING: begin
					gvt <= gvt_next;
					if (gvt > end_time_q) begin
						state <= phold_pkg::ST_FINISHED;
					end
				end
				default: state <= phold_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (q_clear) begin
			end_time_q <= end_time;
		end
	end

	rr_arbiter u_rcv_arb ( // Offers from finished cores
		.clk   (clk),
		.rst_n (rst_n),
		.req   (rcv_req),
		.vgnt  (rcv_vgnt),
		.egnt  (rcv_egnt),
		.eval  (rcv_eval)
	);

	rr_arbiter u_send_arb ( // Free cores
		.clk   (clk),
		.rst_n (rst_n),
		.req   (send_req),
		.vgnt  (send_vgnt),
		.egnt  (send_egnt),
		.eval  (send_eval)
	);

	event_queue u_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (q_clear),
		.enq       (q_enq),
		.deq       (q_deq),
		.in_time   (q_in_time),
		.in_lp     (q_in_lp),
		.head_time (q_head_time),
		.head_lp   (q_head_lp),
		.empty     (q_empty),
		.full      (q_full),
		.count     (q_count)
	);

	prng_lfsr u_prng (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (q_clear),
		.seed  (seed),
		.next  (q_deq),
		.rnd   (rnd)
	);

	genvar g;
	generate
		for (g = 0; g < N_CORE; g++) begin : gen_core
			// Outside a run the granted offer is acked and dropped
			phold_core u_core (
				.clk        (clk),
				.rst_n      (rst_n),
				.event_vld  (q_deq && send_vgnt[g]),
				.event_time (q_head_time),
				.event_lp   (q_head_lp),
				.random_in  (rnd),
				.ready      (send_req[g]),
				.busy_time  (core_busy_time[g]),
				.held       (core_held[g]),
				.new_rq     (rcv_req[g]),
				.new_time   (core_new_time[g]),
				.new_lp     (core_new_lp[g]),
				.ack        (rcv_vgnt[g] && !q_full)
			);
		end
	endgenerate

endmodule

/* hdl/phold_cfg.svh */
`ifndef PHOLD_CFG_SVH
`define PHOLD_CFG_SVH

// Logical processes and processing cores
`define PHOLD_NUM_LP      8
`define PHOLD_NUM_CORE    4

// Event timestamp width in bits
`define PHOLD_TIME_WID    16

// Queue capacity, above the LP count
`define PHOLD_Q_DEPTH     16

// Cycles a core spends on one event
`define PHOLD_PROC_CYCLES 4

// Increment is MIN_DELAY plus masked random bits, so 1 to 15
`define PHOLD_MIN_DELAY   1
`define PHOLD_DELAY_MASK  14

`endif

/* hdl/phold_core.sv */
`timescale 1ns/1ps
`include "phold_cfg.svh"

module phold_core (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             event_vld,
	input  phold_pkg::time_t event_time,
	input  phold_pkg::lp_t   event_lp,
	input  logic [7:0]       random_in,
	output logic             ready,
	output phold_pkg::time_t busy_time,
	output logic             held,
	output logic             new_rq,
	output phold_pkg::time_t new_time,
	output phold_pkg::lp_t   new_lp,
	input  logic             ack
);

	localparam int CNT_WID = $clog2(`PHOLD_PROC_CYCLES + 1);

	typedef enum logic [1:0] {
		CS_FREE,
		CS_PROC,
		CS_OFFER
	} core_state_e;

	core_state_e        state;
	logic [CNT_WID-1:0] cnt;
	phold_pkg::time_t   time_q;
	logic [7:0]         rnd_q;

	assign ready     = (state == CS_FREE);
	assign held      = (state != CS_FREE);
	assign new_rq    = (state == CS_OFFER);
	assign busy_time = time_q;

	// Lookahead plus masked upper random bits
	assign new_time = time_q + phold_pkg::time_t'(`PHOLD_MIN_DELAY)
		+ phold_pkg::time_t'(rnd_q[7:4] & 4'(`PHOLD_DELAY_MASK));

	// Random target LP
	assign new_lp = phold_pkg::lp_t'(rnd_q % 8'(`PHOLD_NUM_LP));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CS_FREE;
			cnt   <= '0;
		end else begin
			case (state)
				CS_FREE: if (event_vld) begin
					state <= CS_PROC;
					cnt   <= '0;
				end
				CS_PROC: if (cnt == CNT_WID'(`PHOLD_PROC_CYCLES - 1)) begin
					state <= CS_OFFER;
				end else begin
					cnt <= cnt + 1'b1;
				end
				CS_OFFER: if (ack) begin
					state <= CS_FREE; // Request drops next cycle
				end
				default: state <= CS_FREE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == CS_FREE && event_vld) begin
			time_q <= event_time;
			rnd_q  <= random_in;
		end
	end

endmodule

/* hdl/phold_pkg.sv */
`include "phold_cfg.svh"

package phold_pkg;

	// Controller sequence
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_INIT,
		ST_RUNNING,
		ST_FINISHED
	} ctrl_state_e;

	// Event fields
	localparam int LP_WID = $clog2(`PHOLD_NUM_LP);

	typedef logic [`PHOLD_TIME_WID-1:0] time_t;
	typedef logic [LP_WID-1:0]          lp_t;

endpackage

/* hdl/prng_lfsr.sv */
`timescale 1ns/1ps

module prng_lfsr (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        load,
	input  logic [15:0] seed,
	input  logic        next,
	output logic [7:0]  rnd
);

	logic [15:0] lfsr;
	logic        fb;

	// Taps 16,14,13,11 give the full period
	assign fb  = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
	assign rnd = lfsr[7:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr <= 16'hffff;
		end else if (load) begin
			lfsr <= (seed == 16'h0000) ? 16'hffff : seed; // All zeros would lock up
		end else if (next) begin
			lfsr <= {lfsr[14:0], fb};
		end
	end

endmodule

/* hdl/rr_arbiter.sv */
`timescale 1ns/1ps
`include "phold_cfg.svh"

module rr_arbiter (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [`PHOLD_NUM_CORE-1:0]         req,
	output logic [`PHOLD_NUM_CORE-1:0]         vgnt,
	output logic [$clog2(`PHOLD_NUM_CORE)-1:0] egnt,
	output logic                              eval
);

	localparam int N       = `PHOLD_NUM_CORE;
	localparam int IDX_WID = $clog2(N);

	logic [IDX_WID-1:0] ptr; // First candidate this cycle

	// First request at or after the pointer
	always_comb begin
		int   idx;
		logic found;
		egnt  = '0;
		found = 1'b0;
		for (int i = 0; i < N; i++) begin
			idx = (int'(ptr) + i) % N;
			if (!found && req[idx]) begin
				egnt  = IDX_WID'(idx);
				found = 1'b1;
			end
		end
	end

	assign eval = |req;
	assign vgnt = eval ? (N'(1) << egnt) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (eval) begin
			ptr <= (egnt == IDX_WID'(N - 1)) ? '0 : egnt + 1'b1; // Skip past winner
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the PHOLD regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module phold_tb -o Vphold_tb

out=$(./obj_dir/Vphold_tb)
echo "$out"
echo "$out" | grep -q "^Regression passed$"

/* verif/phold_checker.sv */
`timescale 1ns/1ps

module phold_checker (
	input logic                   clk,
	input logic                   rst_n,
	input phold_pkg::ctrl_state_e state,
	input phold_pkg::time_t       gvt,
	input logic                   done,
	input logic                   evt_vld,
	input phold_pkg::time_t       evt_time,
	input logic                   rcv_eval,
	input logic                   q_full
);

	// No event leaves behind GVT
	evt_not_before_gvt: assert property (@(posedge clk) disable iff (!rst_n)
		evt_vld |-> evt_time >= gvt)
		else $error("dispatched event time %0d below gvt %0d", evt_time, gvt);

	gvt_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
		state == phold_pkg::ST_RUNNING |=> gvt >= $past(gvt))
		else $error("gvt went backwards to %0d", gvt);

	// Seeds and core offers always find room
	enq_not_full: assert property (@(posedge clk) disable iff (!rst_n)
		(state == phold_pkg::ST_INIT || (state == phold_pkg::ST_RUNNING && rcv_eval))
		|-> !q_full)
		else $error("enqueue into a full event queue");

	done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done held for more than one cycle");

endmodule

bind phold phold_checker u_checker (
	.clk      (clk),
	.rst_n    (rst_n),
	.state    (state),
	.gvt      (gvt),
	.done     (done),
	.evt_vld  (evt_vld),
	.evt_time (evt_time),
	.rcv_eval (rcv_eval),
	.q_full   (q_full)
);

/* verif/phold_tb.sv */
`timescale 1ns/1ps
`include "phold_cfg.svh"

module phold_tb;

	localparam int MAX_TESTS = 16;
	localparam int DRAIN     = 20; // Idle cycles after done, cores empty out
	localparam int MAX_INC   = `PHOLD_MIN_DELAY + `PHOLD_DELAY_MASK;
	localparam int MIN_GAP   = `PHOLD_PROC_CYCLES + 2; // Busy, one offer cycle, then free

	logic                               clk;
	logic                               rst_n;
	logic                               start;
	logic [15:0]                        seed;
	phold_pkg::time_t                   end_time;
	phold_pkg::time_t                   gvt;
	logic                               done;
	logic                               evt_vld;
	phold_pkg::time_t                   evt_time;
	phold_pkg::lp_t                     evt_lp;
	logic [$clog2(`PHOLD_NUM_CORE)-1:0] evt_core;

	logic [15:0]      tests [3*MAX_TESTS]; // Seed, end time, budget
	int               errors;
	int               run_count;
	phold_pkg::time_t run_gvt;

	phold DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.seed     (seed),
		.end_time (end_time),
		.gvt      (gvt),
		.done     (done),
		.evt_vld  (evt_vld),
		.evt_time (evt_time),
		.evt_lp   (evt_lp),
		.evt_core (evt_core)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_time(input phold_pkg::time_t got, input phold_pkg::time_t lo,
		input phold_pkg::time_t hi, input string what);
		if (got < lo || got > hi) begin
			errors++;
			$display("** Error at %0t: %s is %0d, expected %0d to %0d", $time, what, got, lo, hi);
		end
	endtask

	task automatic check_lp(input phold_pkg::lp_t got, input phold_pkg::lp_t exp,
		input string what);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_core_gap(input logic [$clog2(`PHOLD_NUM_CORE)-1:0] core,
		input int gap, input string what);
		if (gap < MIN_GAP) begin
			errors++;
			$display("** Error at %0t: %s %0d reused after %0d cycles, expected at least %0d",
				$time, what, core, gap, MIN_GAP);
		end
	endtask

	// One run from the start strobe to the end of the drain window
	task automatic run_phold(input logic [15:0] s, input phold_pkg::time_t et, input int budget);
		int               cycles;
		int               c;
		int               last_disp [`PHOLD_NUM_CORE];
		bit               finished;
		phold_pkg::time_t hi;
		run_count = 0;
		finished  = 1'b0;
		for (c = 0; c < `PHOLD_NUM_CORE; c++) begin
			last_disp[c] = -MIN_GAP;
		end
		@(posedge clk);
		#1;
		start    = 1'b1;
		seed     = s;
		end_time = et;
		@(posedge clk);
		#1;
		start = 1'b0;
		for (cycles = 0; cycles < budget && !finished; cycles++) begin
			@(negedge clk);
			if (evt_vld) begin
				if (run_count < `PHOLD_NUM_LP) begin // Seeds leave in arrival order
					check_time(evt_time, '0, '0, "seed event time");
					check_lp(evt_lp, phold_pkg::lp_t'(run_count), "seed event LP");
				end else begin
					hi = gvt + phold_pkg::time_t'(MAX_INC);
					check_time(evt_time, gvt, hi, "dispatched event time");
				end
				check_core_gap(evt_core, cycles - last_disp[evt_core], "core");
				last_disp[evt_core] = cycles;
				run_count++;
			end
			if (done) begin
				finished = 1'b1;
			end
		end
		if (!finished) begin
			errors++;
			$display("Timeout: done did not pulse within %0d cycles after start", budget);
		end else begin
			check_time(gvt, phold_pkg::time_t'(et + 16'd1), '1, "final gvt");
		end
		run_gvt = gvt;
		for (cycles = 0; cycles < DRAIN; cycles++) begin
			@(negedge clk);
			if (evt_vld || done) begin
				errors++;
				$display("At %0t the DUT dispatched or signalled done after the run ended", $time);
			end
		end
	endtask

	initial begin
		int               i;
		int               t;
		int               n_tests;
		int               n_fail;
		int               err_before;
		int               first_count;
		phold_pkg::time_t first_gvt;
		rst_n    = 1'b0;
		start    = 1'b0;
		seed     = '0;
		end_time = '0;
		errors   = 0;
		n_tests  = 0;
		n_fail   = 0;
		for (i = 0; i < 3 * MAX_TESTS; i++) begin
			tests[i] = '0; // Zero budget ends the list
		end
		$readmemh("verif/phold_tests.txt", tests);
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (i = 0; i < 8; i++) begin
			@(negedge clk);
			check_time(gvt, '0, '0, "gvt after reset");
			if (evt_vld || done) begin
				errors++;
				$display("At %0t the DUT was active after reset without a start", $time);
			end
		end
		for (t = 0; t < MAX_TESTS && tests[3*t+2] != 16'd0; t++) begin
			err_before = errors;
			run_phold(tests[3*t], tests[3*t+1], int'(tests[3*t+2]));
			first_count = run_count;
			first_gvt   = run_gvt;
			run_phold(tests[3*t], tests[3*t+1], int'(tests[3*t+2])); // Same seed again
			check_count(run_count, first_count, "dispatch count on rerun");
			check_time(run_gvt, first_gvt, first_gvt, "final gvt on rerun");
			n_tests++;
			if (errors != err_before) begin
				n_fail++;
			end
			$display("Test %0d: seed %h end %0d, %0d events, gvt %0d, %s", t, tests[3*t],
				tests[3*t+1], first_count, first_gvt, (errors == err_before) ? "ok" : "FAILED");
		end
		$display("%0d tests, %0d ok, %0d failed, %0d errors", n_tests, n_tests - n_fail,
			n_fail, errors);
		if (errors == 0 && n_tests > 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* verif/phold_tests.txt */
// Columns in hex: seed, end time, cycle budget from start to done
// A line of zeros closes the list, a zero seed checks the seed fixup
ace1 0020 0200
0001 0040 0400
0000 0080 0800
ffff 0100 1000
95a3 0200 2000
5a5a 0300 2800
1234 03e8 3000
0000 0000 0000
